/* src/elink_params.svh */
// elink receive configuration constants
// register group decode, register map and watchdog idle limits
// shared by the register file and the watchdog

`ifndef ELINK_PARAMS_SVH
`define ELINK_PARAMS_SVH

//##############################
// register group decode
//##############################
`define ECFG_GROUP 4'h0         // hit when addr[19:15] == {group, 1'b0}
`define ECFG_RFAW  5            // index field is addr[RFAW+1:2]

//##############################
// register indexes
//##############################
`define ELRXCFG   5'd0          // config word
`define ELRXGPIO  5'd1          // synchronized gpio pins, read only
`define ELRXBASE  5'd2          // dynamic remap base
`define ELRXDEBUG 5'd3          // sticky flags, write one to clear

//##############################
// watchdog idle limits
//##############################
`define TIMER_LIM1 9'd16        // timer_cfg == 1
`define TIMER_LIM2 9'd64        // timer_cfg == 2
`define TIMER_LIM3 9'd256       // timer_cfg == 3

`endif

/* src/mi_pkg.sv */
// memory-mapped register port types
// 20-bit physical address, 32-bit data words, register index field

`include "elink_params.svh"

package mi_pkg;

   // full physical address as seen on the port, no shifting
   typedef logic [19:0] mi_addr_t;

   // one register word, writes are always full words
   typedef logic [31:0] mi_data_t;

   // register index, taken from addr[RFAW+1:2]
   typedef logic [`ECFG_RFAW-1:0] reg_idx_t;

endpackage

/* src/erx_pkg.sv */
// receive path types
// transaction address, remap controls, watchdog select and state,
// gpio sample and sticky debug flags

package erx_pkg;

   typedef logic [31:0] pkt_addr_t;     // incoming transaction address
   typedef logic [11:0] remap_field_t;  // upper addr bits 31:20, sel and pattern
   typedef logic [1:0]  remap_mode_t;   // remap rule select
   typedef logic [1:0]  timer_cfg_t;    // watchdog limit select, 0 = off
   typedef logic [8:0]  gpio_t;         // frame + data pins
   typedef logic [3:0]  dbg_flags_t;    // [2:0] debug_vector, [3] timeout

   //##############################
   // remap mode codes
   //##############################
   // 3 also passes through, same as none
   localparam remap_mode_t REMAP_NONE    = 2'd0;
   localparam remap_mode_t REMAP_STATIC  = 2'd1;  // bit-select replace
   localparam remap_mode_t REMAP_DYNAMIC = 2'd2;  // add base

   //##############################
   // watchdog fsm
   //##############################
   typedef enum logic
   {
      tmr_idle,                         // waiting for a packet
      tmr_counting                      // counting idle cycles
   } timer_state_t;

endpackage

/* src/ecfg_rx.sv */
// receive configuration register file
// decodes the register group and index, holds the config word and the
// dynamic remap base, synchronizes the gpio pins, keeps sticky debug
// flags (write one to clear) and returns read data one cycle later

`include "elink_params.svh"

module ecfg_rx
(
   input  logic                   sys_clk,
   input  logic                   reset,
   // register port
   input  logic                   mi_en,
   input  logic                   mi_we,
   input  mi_pkg::mi_addr_t       mi_addr,
   input  mi_pkg::mi_data_t       mi_din,
   output mi_pkg::mi_data_t       mi_dout,
   // status inputs
   input  erx_pkg::gpio_t         gpio_datain,
   input  logic [15:0]            debug_vector,  // only [2:0] kept
   input  logic                   timeout,       // one cycle pulse
   // config outputs
   output logic                   mmu_enable,
   output erx_pkg::remap_mode_t   remap_mode,
   output erx_pkg::remap_field_t  remap_sel,
   output erx_pkg::remap_field_t  remap_pattern,
   output erx_pkg::pkt_addr_t     remap_base,
   output erx_pkg::timer_cfg_t    timer_cfg
);

   import mi_pkg::*;
   import erx_pkg::*;

   logic       group_hit;
   logic       cfg_read;
   logic       cfg_write;
   reg_idx_t   reg_idx;
   logic       rx_cfg_write;
   logic       base_write;
   logic       debug_write;
   mi_data_t   rx_cfg_reg;                     // config word
   pkt_addr_t  base_reg;                       // dynamic remap base
   gpio_t      gpio_sync;                      // first sync stage
   gpio_t      gpio_reg;                       // second sync stage
   dbg_flags_t dbg_flags;
   dbg_flags_t dbg_set;
   mi_data_t   rd_data;

   //##############################
   // address decode
   //##############################
   assign group_hit = (mi_addr[19:15] == {`ECFG_GROUP, 1'b0});
   assign reg_idx   = mi_addr[`ECFG_RFAW+1:2];

   assign cfg_write = mi_en &  mi_we & group_hit;
   assign cfg_read  = mi_en & ~mi_we & group_hit;

   assign rx_cfg_write = cfg_write & (reg_idx == `ELRXCFG);
   assign base_write   = cfg_write & (reg_idx == `ELRXBASE);
   assign debug_write  = cfg_write & (reg_idx == `ELRXDEBUG);

   //##############################
   // config word + remap base
   //##############################
   always_ff @(posedge sys_clk)
   begin
      if (reset)
      begin
         rx_cfg_reg <= '0;
         base_reg   <= '0;
      end
      else
      begin
         if (rx_cfg_write)
            rx_cfg_reg <= mi_din;
         if (base_write)
            base_reg   <= mi_din;
      end
   end

   // field split of the config word, bit 0 and 31:30 unused
   assign mmu_enable    = rx_cfg_reg[1];
   assign remap_mode    = rx_cfg_reg[3:2];
   assign remap_sel     = rx_cfg_reg[15:4];
   assign remap_pattern = rx_cfg_reg[27:16];
   assign timer_cfg     = rx_cfg_reg[29:28];
   assign remap_base    = base_reg;

   //##############################
   // gpio synchronizer
   //##############################
   always_ff @(posedge sys_clk)
   begin
      gpio_sync <= gpio_datain;                // async pins, may go metastable
      gpio_reg  <= gpio_sync;
   end

   //##############################
   // sticky debug flags
   //##############################
   assign dbg_set = {timeout, debug_vector[2:0]};

   always_ff @(posedge sys_clk)
   begin
      if (reset)
         dbg_flags <= '0;
      else if (debug_write)
         dbg_flags <= (dbg_flags & ~mi_din[3:0]) | dbg_set;  // set beats clear
      else
         dbg_flags <= dbg_flags | dbg_set;
   end

   //##############################
   // readback mux
   //##############################
   always_comb
   begin
      case (reg_idx)
         `ELRXCFG:   rd_data = rx_cfg_reg;
         `ELRXGPIO:  rd_data = {23'd0, gpio_reg};      // pins from two cycles back
         `ELRXBASE:  rd_data = base_reg;
         `ELRXDEBUG: rd_data = {28'd0, dbg_flags};
         default:    rd_data = '0;                     // unmapped
      endcase
   end

   // registered read, holds between reads
   always_ff @(posedge sys_clk)
   begin
      if (reset)
         mi_dout <= '0;
      else if (cfg_read)
         mi_dout <= rd_data;
   end

endmodule

/* src/erx_remap.sv */
// receive address remapper
// static mode swaps the selected upper address bits for a pattern,
// dynamic mode adds a base offset, other modes pass through
// one register stage, a new packet may arrive every cycle

module erx_remap
(
   input  logic                   sys_clk,
   input  logic                   reset,
   // incoming transaction
   input  logic                   pkt_valid,
   input  erx_pkg::pkt_addr_t     pkt_addr,
   // remap config
   input  erx_pkg::remap_mode_t   remap_mode,
   input  erx_pkg::remap_field_t  remap_sel,
   input  erx_pkg::remap_field_t  remap_pattern,
   input  erx_pkg::pkt_addr_t     remap_base,
   // remapped transaction, one cycle later
   output logic                   remap_valid,
   output erx_pkg::pkt_addr_t     remap_addr
);

   import erx_pkg::*;

   pkt_addr_t    static_addr;
   pkt_addr_t    dynamic_addr;
   pkt_addr_t    next_addr;
   remap_field_t static_upper;

   //##############################
   // remap rules
   //##############################
   // sel bit set -> take pattern bit, else keep address bit
   assign static_upper = (pkt_addr[31:20] & ~remap_sel) | (remap_pattern & remap_sel);
   assign static_addr  = {static_upper, pkt_addr[19:0]};

   assign dynamic_addr = pkt_addr + remap_base;        // wraps at 2**32

   always_comb
   begin
      case (remap_mode)
         REMAP_STATIC:  next_addr = static_addr;
         REMAP_DYNAMIC: next_addr = dynamic_addr;
         default:       next_addr = pkt_addr;          // none, or code 3
      endcase
   end

   //##############################
   // output stage
   //##############################
   always_ff @(posedge sys_clk)
   begin
      if (reset)
         remap_valid <= 1'b0;
      else
         remap_valid <= pkt_valid;
   end

   always_ff @(posedge sys_clk)
   begin
      remap_addr <= next_addr;                         // payload, qualified by valid
   end

endmodule

/* src/erx_timer.sv */
// receive idle watchdog
// arms on every packet and counts idle cycles after the last one;
// raises a one cycle timeout pulse when the count reaches the limit
// selected by timer_cfg, then drops back to idle

`include "elink_params.svh"

module erx_timer
(
   input  logic                 sys_clk,
   input  logic                 reset,
   input  logic                 pkt_valid,
   input  erx_pkg::timer_cfg_t  timer_cfg,   // 0 = watchdog off
   output logic                 timeout      // one cycle pulse
);

   import erx_pkg::*;

   timer_state_t state;
   logic [8:0]   idle_cnt;                    // up to 255, limit - 1
   logic [8:0]   limit;
   logic         at_limit;

   //##############################
   // limit select
   //##############################
   always_comb
   begin
      case (timer_cfg)
         2'd1:    limit = `TIMER_LIM1;
         2'd2:    limit = `TIMER_LIM2;
         default: limit = `TIMER_LIM3;        // cfg 0 never counts
      endcase
   end

   // cycle after the packet is count 1, pulse lands on cycle LIM
   assign at_limit = (idle_cnt >= limit - 9'd1);

   //##############################
   // watchdog fsm
   //##############################
   always_ff @(posedge sys_clk)
   begin
      if (reset)
      begin
         state    <= tmr_idle;
         idle_cnt <= '0;
         timeout  <= 1'b0;
      end
      else
      begin
         timeout <= 1'b0;                     // default, pulse only
         if (timer_cfg == 2'd0)
            state <= tmr_idle;                // disabled, also aborts a count
         else if (pkt_valid)
         begin
            state    <= tmr_counting;         // arm or restart
            idle_cnt <= 9'd1;
         end
         else if (state == tmr_counting)
         begin
            if (at_limit)
            begin
               timeout <= 1'b1;
               state   <= tmr_idle;
            end
            else
               idle_cnt <= idle_cnt + 9'd1;
         end
      end
   end

endmodule

/* src/erx_cfg_top.sv */
// receive configuration subsystem top
// register file driving the address remapper and the idle watchdog,
// watchdog timeouts fed back into the sticky debug flags

module erx_cfg_top
(
   input  logic                 sys_clk,
   input  logic                 reset,
   // register port
   input  logic                 mi_en,
   input  logic                 mi_we,
   input  mi_pkg::mi_addr_t     mi_addr,
   input  mi_pkg::mi_data_t     mi_din,
   output mi_pkg::mi_data_t     mi_dout,
   // status inputs
   input  erx_pkg::gpio_t       gpio_datain,
   input  logic [15:0]          debug_vector,
   // packet path
   input  logic                 pkt_valid,
   input  erx_pkg::pkt_addr_t   pkt_addr,
   output logic                 remap_valid,
   output erx_pkg::pkt_addr_t   remap_addr,
   // to downstream mmu
   output logic                 mmu_enable
);

   import erx_pkg::*;

   remap_mode_t  remap_mode;
   remap_field_t remap_sel;
   remap_field_t remap_pattern;
   pkt_addr_t    remap_base;
   timer_cfg_t   timer_cfg;
   logic         timeout;                  // watchdog -> debug flag 3

   ecfg_rx ecfg_rx0
   (
      .sys_clk       (sys_clk),
      .reset         (reset),
      .mi_en         (mi_en),
      .mi_we         (mi_we),
      .mi_addr       (mi_addr),
      .mi_din        (mi_din),
      .mi_dout       (mi_dout),
      .gpio_datain   (gpio_datain),
      .debug_vector  (debug_vector),
      .timeout       (timeout),
      .mmu_enable    (mmu_enable),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base),
      .timer_cfg     (timer_cfg)
   );

   erx_remap erx_remap0
   (
      .sys_clk       (sys_clk),
      .reset         (reset),
      .pkt_valid     (pkt_valid),
      .pkt_addr      (pkt_addr),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base),
      .remap_valid   (remap_valid),
      .remap_addr    (remap_addr)
   );

   erx_timer erx_timer0
   (
      .sys_clk   (sys_clk),
      .reset     (reset),
      .pkt_valid (pkt_valid),
      .timer_cfg (timer_cfg),
      .timeout   (timeout)
   );

endmodule

/* sim/erx_cfg_checker.sv */
// bound assertions on the receive configuration top
// packet valid timing, watchdog off, read data hold between reads

`include "elink_params.svh"

module erx_cfg_checker
(
   input logic                 sys_clk,
   input logic                 reset,
   input logic                 mi_en,
   input logic                 mi_we,
   input mi_pkg::mi_addr_t     mi_addr,
   input mi_pkg::mi_data_t     mi_dout,
   input logic                 pkt_valid,
   input logic                 remap_valid,
   input erx_pkg::timer_cfg_t  timer_cfg,
   input logic                 timeout
);

   int   fail_cnt = 0;                         // summed into the testbench total
   logic rd_cycle;

   assign rd_cycle = mi_en & ~mi_we & (mi_addr[19:15] == {`ECFG_GROUP, 1'b0});

   a_remap_valid: assert property (@(posedge sys_clk) disable iff (reset)
      remap_valid == $past(pkt_valid))
   else
   begin
      fail_cnt++;
      $error("remap_valid does not follow pkt_valid by one cycle");
   end

   // pulse is registered, so look at the config it was made with
   a_timeout_off: assert property (@(posedge sys_clk) disable iff (reset)
      ($past(timer_cfg) == 2'd0) |-> !timeout)
   else
   begin
      fail_cnt++;
      $error("watchdog pulse with timer_cfg 0");
   end

   a_dout_hold: assert property (@(posedge sys_clk) disable iff (reset)
      !rd_cycle |=> $stable(mi_dout))
   else
   begin
      fail_cnt++;
      $error("mi_dout changed without a read");
   end

endmodule

bind erx_cfg_top erx_cfg_checker chk0
(
   .sys_clk     (sys_clk),
   .reset       (reset),
   .mi_en       (mi_en),
   .mi_we       (mi_we),
   .mi_addr     (mi_addr),
   .mi_dout     (mi_dout),
   .pkt_valid   (pkt_valid),
   .remap_valid (remap_valid),
   .timer_cfg   (timer_cfg),
   .timeout     (timeout)
);

/* sim/erx_cfg_tb.sv */
// testbench for the receive configuration subsystem
// register readback, gpio sync, address remap, watchdog timing and
// sticky debug flags, all checked against reference functions

`include "elink_params.svh"

module erx_cfg_tb;

   import mi_pkg::*;
   import erx_pkg::*;

   logic        sys_clk;
   logic        reset;
   logic        mi_en;
   logic        mi_we;
   mi_addr_t    mi_addr;
   mi_data_t    mi_din;
   mi_data_t    mi_dout;
   gpio_t       gpio_datain;
   logic [15:0] debug_vector;
   logic        pkt_valid;
   pkt_addr_t   pkt_addr;
   logic        remap_valid;
   pkt_addr_t   remap_addr;
   logic        mmu_enable;

   int          err_cnt = 0;
   int          chk_cnt = 0;
   pkt_addr_t   exp_q[$];                      // expected remap_addr, oldest first
   mi_data_t    cfg_model;                     // what the config word should hold
   pkt_addr_t   base_model;
   gpio_t       gpio_model;
   dbg_flags_t  dbg_model;

   erx_cfg_top dut0 (.*);

   initial
   begin
      sys_clk = 1'b0;
      forever #5 sys_clk = ~sys_clk;
   end

   //##############################
   // reference functions
   //##############################
   function automatic pkt_addr_t remap_ref(pkt_addr_t a, mi_data_t cfg, pkt_addr_t base);
      pkt_addr_t r;
      r = a;
      if (cfg[3:2] == 2'd1)                    // static, bit by bit
      begin
         for (int i = 0; i < 12; i++)
            if (cfg[4+i])
               r[20+i] = cfg[16+i];
      end
      else if (cfg[3:2] == 2'd2)
         r = a + base;                         // dynamic, wraps
      return r;
   endfunction

   function automatic mi_data_t read_ref(reg_idx_t idx);
      case (idx)
         `ELRXCFG:   return cfg_model;
         `ELRXGPIO:  return {23'd0, gpio_model};
         `ELRXBASE:  return base_model;
         `ELRXDEBUG: return {28'd0, dbg_model};
         default:    return '0;                // unmapped
      endcase
   endfunction

   // cycles from the packet to the pulse, 0 = never
   function automatic int timeout_cycle_ref(timer_cfg_t tcfg);
      case (tcfg)
         2'd1:    return 16;
         2'd2:    return 64;
         2'd3:    return 256;
         default: return 0;
      endcase
   endfunction

   //##############################
   // compare tasks
   //##############################
   task automatic check_data(string name, mi_data_t exp, mi_data_t act);
      chk_cnt++;
      if (act !== exp)
      begin
         err_cnt++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_addr(string name, pkt_addr_t exp, pkt_addr_t act);
      chk_cnt++;
      if (act !== exp)
      begin
         err_cnt++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_flags(string name, dbg_flags_t exp, dbg_flags_t act);
      chk_cnt++;
      if (act !== exp)
      begin
         err_cnt++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_count(string name, int exp, int act);
      chk_cnt++;
      if (act != exp)
      begin
         err_cnt++;
         $display("ERR %s expected %0d actual %0d", name, exp, act);
      end
   endtask

   //##############################
   // bus and packet drivers
   //##############################
   function automatic mi_addr_t reg_addr(reg_idx_t idx);
      return {`ECFG_GROUP, 1'b0, 8'd0, idx, 2'b00};
   endfunction

   task automatic reg_write(mi_addr_t addr, mi_data_t data);
      @(posedge sys_clk);
      mi_en   <= 1'b1;
      mi_we   <= 1'b1;
      mi_addr <= addr;
      mi_din  <= data;
      @(posedge sys_clk);                      // write lands here
      mi_en   <= 1'b0;
      mi_we   <= 1'b0;
   endtask

   task automatic reg_read(mi_addr_t addr, output mi_data_t data);
      @(posedge sys_clk);
      mi_en   <= 1'b1;
      mi_we   <= 1'b0;
      mi_addr <= addr;
      @(posedge sys_clk);
      mi_en   <= 1'b0;
      @(negedge sys_clk);                      // dout one cycle after the read
      data = mi_dout;
   endtask

   task automatic send_packet(pkt_addr_t addr);
      @(posedge sys_clk);
      pkt_valid <= 1'b1;
      pkt_addr  <= addr;
      exp_q.push_back(remap_ref(addr, cfg_model, base_model));
   endtask

   task automatic end_packets();
      @(posedge sys_clk);
      pkt_valid <= 1'b0;
   endtask

   task automatic wait_remap_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < 20)
      begin
         @(negedge sys_clk);
         n++;
      end
      if (exp_q.size() != 0)
      begin
         err_cnt++;
         $display("remap_valid missing for %0d packets after 20 cycles", exp_q.size());
      end
   endtask

   // counts from the edge that took the packet, first cycle = 1
   task automatic count_to_timeout(int max_cycles, output int cycles, output logic hit);
      cycles = 0;
      hit    = 1'b0;
      while (!hit && cycles < max_cycles)
      begin
         @(negedge sys_clk);
         cycles++;
         hit = dut0.timeout;
      end
   endtask

   task automatic set_timer(timer_cfg_t tcfg);
      cfg_model = {2'b00, tcfg, 28'd0};        // remap off, mmu off
      reg_write(reg_addr(`ELRXCFG), cfg_model);
   endtask

   //##############################
   // remap compare process
   //##############################
   initial
   begin
      forever
      begin
         @(negedge sys_clk);
         if (!reset && remap_valid)
         begin
            if (exp_q.size() == 0)
            begin
               err_cnt++;
               $display("remap_valid raised with no packet outstanding");
            end
            else
               check_addr("remap_addr", exp_q.pop_front(), remap_addr);
         end
      end
   end

   //##############################
   // stimulus
   //##############################
   initial
   begin
      logic [31:0] rnd;
      mi_data_t    rd;
      int          lim;
      int          cycles;
      logic        hit;
      dbg_flags_t  clr;

      rnd          = $urandom(32'h5fb7);       // seed the run
      reset        = 1'b1;
      mi_en        = 1'b0;
      mi_we        = 1'b0;
      mi_addr      = '0;
      mi_din       = '0;
      gpio_datain  = '0;
      debug_vector = '0;
      pkt_valid    = 1'b0;
      pkt_addr     = '0;
      cfg_model    = '0;
      base_model   = '0;
      gpio_model   = '0;
      dbg_model    = '0;
      repeat (3) @(posedge sys_clk);
      reset <= 1'b0;
      @(negedge sys_clk);
      check_data("mi_dout after reset", 32'd0, mi_dout);

      // 1. register write and readback
      for (int i = 0; i < 4; i++)
      begin
         cfg_model    = $urandom;
         cfg_model[1] = i[0];                  // both mmu_enable values
         reg_write(reg_addr(`ELRXCFG), cfg_model);
         @(negedge sys_clk);
         check_data("mmu_enable", {31'd0, cfg_model[1]}, {31'd0, mmu_enable});
         base_model = $urandom;
         reg_write(reg_addr(`ELRXBASE), base_model);
         reg_read(reg_addr(`ELRXCFG), rd);
         check_data("config readback", read_ref(`ELRXCFG), rd);
         reg_read(reg_addr(`ELRXBASE), rd);
         check_data("base readback", read_ref(`ELRXBASE), rd);
      end
      reg_read(reg_addr(5'd9), rd);
      check_data("unmapped index", read_ref(5'd9), rd);
      reg_read(reg_addr(`ELRXCFG) | 20'h08000, rd);    // miss, dout keeps the zero
      check_data("outside group read", 32'd0, rd);
      reg_write(reg_addr(`ELRXCFG) | 20'h08000, 32'hffff_ffff);
      reg_read(reg_addr(`ELRXCFG), rd);
      check_data("outside group write", read_ref(`ELRXCFG), rd);

      // 2. gpio readback through the synchronizer
      rnd        = $urandom;
      gpio_model = rnd[8:0];
      @(posedge sys_clk);
      gpio_datain <= gpio_model;
      repeat (3) @(posedge sys_clk);
      reg_read(reg_addr(`ELRXGPIO), rd);
      check_data("gpio readback", read_ref(`ELRXGPIO), rd);

      // 3. back to back packets in every remap mode
      for (int m = 0; m < 4; m++)
      begin
         cfg_model        = $urandom;
         cfg_model[31:28] = 4'd0;              // keep the watchdog off
         cfg_model[3:2]   = 2'(m);
         base_model       = $urandom;
         reg_write(reg_addr(`ELRXCFG), cfg_model);
         reg_write(reg_addr(`ELRXBASE), base_model);
         for (int k = 0; k < 24; k++)
            send_packet($urandom);
         end_packets();
         wait_remap_drain();
      end

      // 4. watchdog limits, restart, disabled
      for (int c = 1; c < 4; c++)
      begin
         lim = timeout_cycle_ref(2'(c));
         set_timer(2'(c));
         send_packet($urandom);
         end_packets();
         count_to_timeout(lim + 40, cycles, hit);
         if (!hit)
         begin
            err_cnt++;
            $display("no watchdog pulse within %0d cycles, timer_cfg %0d", lim + 40, c);
         end
         check_count("watchdog limit", lim, cycles);
      end
      set_timer(2'd1);
      send_packet($urandom);
      end_packets();
      count_to_timeout(8, cycles, hit);        // too early for a pulse
      if (hit)
      begin
         err_cnt++;
         $display("watchdog pulsed after %0d idle cycles, limit 16", cycles);
      end
      send_packet($urandom);                   // restart
      end_packets();
      count_to_timeout(60, cycles, hit);
      check_count("watchdog restart", timeout_cycle_ref(2'd1), cycles);
      set_timer(2'd0);
      send_packet($urandom);
      end_packets();
      count_to_timeout(300, cycles, hit);
      if (hit)
      begin
         err_cnt++;
         $display("watchdog pulsed with timer_cfg 0 after %0d cycles", cycles);
      end
      wait_remap_drain();

      // 5. sticky debug flags
      reg_write(reg_addr(`ELRXDEBUG), 32'h0000_000f);  // drop old timeout flags
      dbg_model = '0;
      rnd       = $urandom;
      @(posedge sys_clk);
      debug_vector <= {13'd0, rnd[2:0] | 3'b001};
      @(posedge sys_clk);
      debug_vector <= '0;
      dbg_model[2:0] = rnd[2:0] | 3'b001;
      set_timer(2'd1);
      send_packet($urandom);
      end_packets();
      count_to_timeout(60, cycles, hit);
      dbg_model[3] = 1'b1;                     // flag sets one cycle after the pulse
      if (!hit)
      begin
         err_cnt++;
         $display("no watchdog pulse for the debug flag test");
      end
      reg_read(reg_addr(`ELRXDEBUG), rd);
      check_flags("debug flags", dbg_model, rd[3:0]);
      clr = {1'b1, rnd[6:5], 1'b0};            // clears the timeout flag, keeps bit 0
      reg_write(reg_addr(`ELRXDEBUG), {28'd0, clr});
      dbg_model = dbg_model & ~clr;
      reg_read(reg_addr(`ELRXDEBUG), rd);
      check_flags("debug clear", dbg_model, rd[3:0]);
      wait_remap_drain();

      err_cnt += dut0.chk0.fail_cnt;
      $display("checks %0d, errors %0d, assertion failures %0d",
               chk_cnt, err_cnt, dut0.chk0.fail_cnt);
      if (err_cnt == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

/* build.f */
+incdir+src
src/mi_pkg.sv
src/erx_pkg.sv
src/ecfg_rx.sv
src/erx_remap.sv
src/erx_timer.sv
src/erx_cfg_top.sv
sim/erx_cfg_checker.sv
sim/erx_cfg_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the receive configuration testbench with verilator
# exit status 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=erx_cfg_sim

verilator --binary --timing --assert \
   -f build.f --top-module erx_cfg_tb -o "$BIN"
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/"$BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1
